//--- files.f
+incdir+verification
src/exec_pkg.sv
src/exec_alu_path.sv
src/exec_move_path.sv
src/exec_result_stage.sv
src/exec_stage.sv
verification/exec_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the execute stage and its testbench with Verilator and runs the simulation.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module exec_stage_tb \
    -Mdir obj_dir -o exec_stage_sim; then
  echo "Verilator compilation failed."
  exit 1
fi

if ! output=$(./obj_dir/exec_stage_sim); then
  echo "$output"
  echo "Simulation exited with an error status."
  exit 1
fi
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "Pass message not found in the simulation output."
exit 1

//--- verification/exec_tb_tasks.svh
`ifndef EXEC_TB_TASKS_SVH
`define EXEC_TB_TASKS_SVH

// ********************************************************************
// Stimulus, reference model and compare tasks
// ********************************************************************

// Base word layout is type, op, eight spare bits, immediate, size bit.
function automatic instr_t build_instr(input logic [3:0] itype, input logic [3:0] op,
                                       input logic [14:0] imm, input logic size,
                                       input word_t ext);
  return {ext, itype, op, 8'h00, imm, size};
endfunction

function automatic word_t sext15(input logic [14:0] imm);
  return {{17{imm[14]}}, imm};
endfunction

function automatic word_t alu_model(input logic [2:0] func, input word_t a, input word_t b);
  word_t r;
  case (func)
    3'd0: r = a + b;
    3'd1: r = a - b;
    3'd2: r = a & b;
    3'd3: r = a | b;
    3'd4: r = a ^ b;
    3'd5: r = a << b[4:0];
    3'd6: r = a >> b[4:0];
    default: r = word_t'($signed(a) >>> b[4:0]);
  endcase
  return r;
endfunction

// Inputs change on the rising edge and outputs are read at the falling edge.
task automatic drive_inputs(input instr_t ir, input word_t pc, input word_t d1,
                            input word_t d2, input logic hold);
  @(posedge clk);
  ir_in    <= ir;
  pc_in    <= pc;
  data1_in <= d1;
  data2_in <= d2;
  stall    <= hold;
  @(negedge clk);
endtask

task automatic apply_reset();
  @(posedge clk);
  rst <= 1'b1;
  repeat (4) @(posedge clk);
  rst <= 1'b0;
endtask

task automatic report_mismatch(input string what, input string got, input string exp);
  errors++;
  $display("FAILED at %0t: %s is %s, expected %s", $time, what, got, exp);
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
  checks++;
  if (got !== exp)
    report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_write(input reg_write_t got, input reg_write_t exp, input string what);
  checks++;
  if (got !== exp)
    report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_ccr(input ccr_t got, input ccr_t exp, input string what);
  checks++;
  if (got !== exp)
    report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
endtask

task automatic check_instr(input instr_t got, input instr_t exp, input string what);
  checks++;
  if (got !== exp)
    report_mismatch(what, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic finish_test(input string name, input int err_before);
  tests_run++;
  $display("Test %-16s done, %0d mismatches.", name, errors - err_before);
endtask

// ********************************************************************
// Directed tests
// ********************************************************************

task automatic alu_test();
  int          err_before;
  word_t       a;
  word_t       b;
  logic [14:0] imm;
  err_before = errors;
  for (int f = 0; f < 8; f++)
  begin
    for (int form = 0; form < 2; form++)
    begin
      a   = $random(seed);
      b   = $random(seed);
      imm = 15'($random(seed));
      drive_inputs(build_instr(T_ALU, {1'(form), 3'(f)}, imm, 1'b0, $random(seed)),
                   32'h0000_0100, a, b, 1'b0);
      check_word(result, alu_model(3'(f), a, (form == 1) ? sext15(imm) : b),
                 $sformatf("ALU function %0d, immediate form %0d", f, form));
      check_write(reg_write, 2'd3, "ALU write mask");
    end
  end
  finish_test("alu_ops", err_before);
endtask

task automatic address_test();
  int          err_before;
  instr_type_e kinds[4] = '{T_LOAD, T_STORE, T_JUMP, T_BRANCH};
  word_t       a;
  word_t       pc;
  word_t       ext;
  word_t       exp_addr;
  logic [14:0] imm;
  err_before = errors;
  for (int k = 0; k < 4; k++)
  begin
    for (int size = 0; size < 2; size++)
    begin
      a        = $random(seed);
      pc       = $random(seed);
      ext      = $random(seed);
      imm      = 15'($random(seed));
      exp_addr = ((kinds[k] == T_BRANCH) ? pc : a) + (sext15(imm) << 2);
      if (size == 1 && kinds[k] != T_BRANCH)
        exp_addr = ext;  // Absolute address from the extension word.
      drive_inputs(build_instr(kinds[k], 4'h0, imm, 1'(size), ext), pc, a, ~a, 1'b0);
      check_word(result, exp_addr,
                 $sformatf("%s address, size bit %0d", kinds[k].name(), size));
      check_write(reg_write, 2'd0, "address write mask");
    end
  end
  finish_test("address_forms", err_before);
endtask

task automatic move_test();
  int          err_before;
  word_t       a;
  word_t       ext;
  logic [14:0] imm;
  err_before = errors;
  for (int size = 0; size < 2; size++)
  begin
    a   = $random(seed);
    ext = $random(seed);
    imm = 15'($random(seed));
    drive_inputs(build_instr(T_LDI, 4'h0, imm, 1'(size), ext), 32'h0, a, 32'h0, 1'b0);
    check_word(result, (size == 1) ? ext : {17'h0, imm}, "LDI value");
    check_write(reg_write, 2'd3, "LDI write mask");
  end
  for (int m = 0; m < 4; m++)
  begin
    a = $random(seed);
    drive_inputs(build_instr(T_MOV, {2'b11, 2'(m)}, 15'h0, 1'b0, 32'h0), 32'h0, a, ~a, 1'b0);
    check_word(result, a, "MOV value");
    check_write(reg_write, 2'(m), "MOV write mask");
  end
  finish_test("moves", err_before);
endtask

task automatic compare_test();
  int    err_before;
  word_t cmp_a[4] = '{32'h0000_1234, 32'hffff_fffb, 32'h0000_0007, 32'h8000_0000};
  word_t cmp_b[4] = '{32'h0000_1234, 32'h0000_0003, 32'hffff_fffe, 32'h0000_0001};
  ccr_t  exp_ccr;
  err_before = errors;
  for (int i = 0; i < 4; i++)
  begin
    // Carry is the unsigned borrow, the middle bit the signed less-than.
    exp_ccr = {cmp_a[i] < cmp_b[i], $signed(cmp_a[i]) < $signed(cmp_b[i]),
               cmp_a[i] == cmp_b[i]};
    drive_inputs(build_instr(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0), 32'h0, cmp_a[i], cmp_b[i], 1'b0);
    check_word(result, cmp_a[i] - cmp_b[i], "CMP difference");
    drive_inputs(build_instr(T_ALU, 4'h0, 15'h0, 1'b0, 32'h0), 32'h0, cmp_b[i], cmp_a[i], 1'b0);
    check_ccr(ccr, exp_ccr, "ccr_o after CMP");
    drive_inputs(build_instr(T_STORE, 4'h0, 15'h4, 1'b0, 32'h0), 32'h0, 32'h9, 32'h1, 1'b0);
    check_ccr(ccr, exp_ccr, "ccr_o after a non-compare");
  end
  finish_test("compare", err_before);
endtask

task automatic stall_test();
  int     err_before;
  instr_t ir_v;
  word_t  pc_v;
  word_t  d1_v;
  instr_t prev_ir;
  word_t  prev_pc;
  word_t  prev_d1;
  err_before = errors;
  for (int i = 0; i < 5; i++)
  begin
    ir_v = build_instr(T_ALU, 4'(i), 15'($random(seed)), 1'b0, $random(seed));
    pc_v = $random(seed);
    d1_v = $random(seed);
    drive_inputs(ir_v, pc_v, d1_v, 32'h0, 1'b0);
    if (i > 0)
    begin
      check_instr(ir_out, prev_ir, "ir_o one cycle later");
      check_word(pc_out, prev_pc, "pc_o one cycle later");
      check_word(data1_out, prev_d1, "reg_data1_o one cycle later");
    end
    prev_ir = ir_v;
    prev_pc = pc_v;
    prev_d1 = d1_v;
  end
  // An equal compare leaves only the zero flag set.
  prev_ir = build_instr(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0);
  drive_inputs(prev_ir, 32'h0000_0400, d1_v, d1_v, 1'b0);
  for (int i = 0; i < 3; i++)
  begin
    drive_inputs(build_instr(T_CMP, 4'h5, 15'h7ff, 1'b0, 32'h0), 32'h0000_0800, ~d1_v, d1_v,
                 1'b1);
    check_instr(ir_out, prev_ir, "ir_o held in stall");
    check_word(pc_out, 32'h0000_0400, "pc_o held in stall");
    check_word(data1_out, d1_v, "reg_data1_o held in stall");
    check_ccr(ccr, 3'b001, "ccr_o held in stall");
  end
  ir_v = build_instr(T_MOV, 4'h3, 15'h0, 1'b0, 32'h0);
  drive_inputs(ir_v, 32'h0000_0c00, 32'h0000_0011, 32'h0, 1'b0);
  check_instr(ir_out, prev_ir, "ir_o at the edge that ends the stall");
  drive_inputs(build_instr(T_LDI, 4'h0, 15'h1, 1'b0, 32'h0), 32'h0000_1000, 32'h0, 32'h0, 1'b0);
  check_instr(ir_out, ir_v, "ir_o after the stall");
  check_word(pc_out, 32'h0000_0c00, "pc_o after the stall");
  check_ccr(ccr, 3'b001, "ccr_o after the stall");
  finish_test("pipeline_stall", err_before);
endtask

task automatic reset_test(input string name, input logic mid_run);
  int err_before;
  err_before = errors;
  if (mid_run)
  begin
    drive_inputs(build_instr(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0), 32'h0000_0200, 32'h1, 32'h2, 1'b0);
    drive_inputs(build_instr(T_ALU, 4'h1, 15'h0, 1'b0, 32'h0), 32'h0000_0204, 32'h5, 32'h6, 1'b0);
    check_ccr(ccr, 3'b110, "ccr_o before reset");
    apply_reset();  // Inputs stay live while reset is held.
  end
  @(negedge clk);
  check_instr(ir_out, '0, "ir_o after reset");
  check_word(pc_out, '0, "pc_o after reset");
  check_word(data1_out, '0, "reg_data1_o after reset");
  check_ccr(ccr, '0, "ccr_o after reset");
  finish_test(name, err_before);
endtask

`endif

//--- verification/exec_stage_tb.sv
`timescale 1ns/1ps

module exec_stage_tb import exec_pkg::*;
();

  localparam int CLK_PERIOD      = 20;
  localparam int NUM_TESTS       = 7;
  localparam int CYCLES_PER_TEST = 40;  // The longest test needs about twenty.
  localparam int MARGIN_CYCLES   = 20;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES;

  logic       clk;
  logic       rst;
  instr_t     ir_in;
  word_t      pc_in;
  word_t      data1_in;
  word_t      data2_in;
  logic       stall;
  word_t      result;
  reg_write_t reg_write;
  instr_t     ir_out;
  word_t      pc_out;
  word_t      data1_out;
  ccr_t       ccr;

  integer seed      = 32'h7965;
  int     errors    = 0;
  int     checks    = 0;
  int     tests_run = 0;

  exec_stage uut (
    .clk_i       (clk),
    .rst_i       (rst),
    .ir_i        (ir_in),
    .pc_i        (pc_in),
    .reg_data1_i (data1_in),
    .reg_data2_i (data2_in),
    .stall_i     (stall),
    .result_o    (result),
    .reg_write_o (reg_write),
    .ir_o        (ir_out),
    .pc_o        (pc_out),
    .reg_data1_o (data1_out),
    .ccr_o       (ccr)
  );

  `include "exec_tb_tasks.svh"

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ********************************************************************
  // Test sequence
  // ********************************************************************

  initial
  begin
    rst      = 1'b1;
    // A compare with live operands sits on the inputs while reset is held.
    ir_in    = build_instr(T_CMP, 4'h0, 15'h0, 1'b0, 32'h0);
    pc_in    = 32'h0000_0100;
    data1_in = 32'h0000_0001;
    data2_in = 32'h0000_0002;
    stall    = 1'b0;
    apply_reset();
    reset_test("power_on_reset", 1'b0);
    alu_test();
    address_test();
    move_test();
    compare_test();
    stall_test();
    reset_test("mid_run_reset", 1'b1);
    $display("Tests run: %0d, checks: %0d, errors: %0d.", tests_run, checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the test sequence did not finish within %0d cycles.", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- src/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import exec_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  instr_t     ir_i,
  input  word_t      pc_i,
  input  word_t      reg_data1_i,
  input  word_t      reg_data2_i,
  input  logic       stall_i,
  output word_t      result_o,
  output reg_write_t reg_write_o,
  output instr_t     ir_o,
  output word_t      pc_o,
  output word_t      reg_data1_o,
  output ccr_t       ccr_o
);

  word_t      alu_result;
  logic       alu_c;
  logic       alu_n;
  logic       alu_v;
  logic       alu_z;
  word_t      move_result;
  logic       move_sel;
  reg_write_t move_write;

  // Arithmetic, address and branch-target computation.
  exec_alu_path u_alu_path (
    .ir_i         (ir_i),
    .pc_i         (pc_i),
    .reg_data1_i  (reg_data1_i),
    .reg_data2_i  (reg_data2_i),
    .alu_result_o (alu_result),
    .alu_c_o      (alu_c),
    .alu_n_o      (alu_n),
    .alu_v_o      (alu_v),
    .alu_z_o      (alu_z)
  );

  exec_move_path u_move_path (
    .ir_i          (ir_i),
    .reg_data1_i   (reg_data1_i),
    .move_result_o (move_result),
    .move_sel_o    (move_sel),
    .move_write_o  (move_write)
  );

  // Merges both paths and owns all clocked state.
  exec_result_stage u_result_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .stall_i       (stall_i),
    .ir_i          (ir_i),
    .pc_i          (pc_i),
    .reg_data1_i   (reg_data1_i),
    .alu_result_i  (alu_result),
    .alu_c_i       (alu_c),
    .alu_n_i       (alu_n),
    .alu_v_i       (alu_v),
    .alu_z_i       (alu_z),
    .move_result_i (move_result),
    .move_sel_i    (move_sel),
    .move_write_i  (move_write),
    .result_o      (result_o),
    .reg_write_o   (reg_write_o),
    .ir_o          (ir_o),
    .pc_o          (pc_o),
    .reg_data1_o   (reg_data1_o),
    .ccr_o         (ccr_o)
  );

endmodule

//--- src/exec_result_stage.sv
`timescale 1ns/1ps

module exec_result_stage import exec_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       stall_i,
  input  instr_t     ir_i,
  input  word_t      pc_i,
  input  word_t      reg_data1_i,
  input  word_t      alu_result_i,
  input  logic       alu_c_i,
  input  logic       alu_n_i,
  input  logic       alu_v_i,
  input  logic       alu_z_i,
  input  word_t      move_result_i,
  input  logic       move_sel_i,
  input  reg_write_t move_write_i,
  output word_t      result_o,
  output reg_write_t reg_write_o,
  output instr_t     ir_o,
  output word_t      pc_o,
  output word_t      reg_data1_o,
  output ccr_t       ccr_o
);

  instr_type_e itype;
  ccr_t        ccr_next;
  logic        ccr_load;

  assign itype = ir_type(ir_i);

  // ********************************************************************
  // Result and write mask
  // ********************************************************************

  assign result_o = move_sel_i ? move_result_i : alu_result_i;

  always_comb
  begin
    if (itype == T_ALU)
      reg_write_o = WRITE_FULL;
    else
      reg_write_o = move_write_i;  // Zero for everything except moves.
  end

  // ********************************************************************
  // Condition codes and pipeline registers
  // ********************************************************************

  // Signed less-than comes from the sign of the difference corrected by overflow.
  assign ccr_next = {alu_c_i, alu_n_i ^ alu_v_i, alu_z_i};
  assign ccr_load = !stall_i && (itype == T_CMP);

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ir_o        <= '0;
      pc_o        <= '0;
      reg_data1_o <= '0;
    end
    else if (!stall_i)
    begin
      ir_o        <= ir_i;
      pc_o        <= pc_i;
      reg_data1_o <= reg_data1_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ccr_o <= '0;
    else if (ccr_load)
      ccr_o <= ccr_next;
  end

  // A stalled cycle must not advance the registered state, compares included.
  stall_hold_chk: assert property (
    @(posedge clk_i) disable iff (rst_i)
      stall_i |=> ($stable(ccr_o) && $stable(pc_o))
  ) else $error("Registered state changed during a stall.");

endmodule

//--- src/exec_move_path.sv
`timescale 1ns/1ps

module exec_move_path import exec_pkg::*;
(
  input  instr_t     ir_i,
  input  word_t      reg_data1_i,
  output word_t      move_result_o,
  output logic       move_sel_o,
  output reg_write_t move_write_o
);

  instr_type_e itype;
  logic [3:0]  op;

  assign itype = ir_type(ir_i);
  assign op    = ir_op(ir_i);

  // ********************************************************************
  // Immediate loads and register moves
  // ********************************************************************

  always_comb
  begin
    move_result_o = reg_data1_i;
    move_sel_o    = 1'b0;
    move_write_o  = WRITE_NONE;
    case (itype)
      T_LDI:
      begin
        move_sel_o   = 1'b1;
        move_write_o = WRITE_FULL;
        if (ir_size(ir_i))
          move_result_o = ir_ext(ir_i);
        else
          move_result_o = ir_uimm(ir_i);
      end
      T_MOV:
      begin
        move_sel_o   = 1'b1;
        move_write_o = reg_write_t'(op[1:0]);  // Half-register moves are allowed.
      end
      default:
      begin
      end
    endcase
  end

  // A mask leaking out of a non-move instruction would corrupt the register file.
  always_comb
  begin
    if (!move_sel_o)
      move_write_chk: assert (move_write_o == WRITE_NONE)
        else $error("Move write mask active without a move instruction.");
  end

endmodule

//--- src/exec_alu_path.sv
`timescale 1ns/1ps

module exec_alu_path import exec_pkg::*;
(
  input  instr_t ir_i,
  input  word_t  pc_i,
  input  word_t  reg_data1_i,
  input  word_t  reg_data2_i,
  output word_t  alu_result_o,
  output logic   alu_c_o,
  output logic   alu_n_o,
  output logic   alu_v_o,
  output logic   alu_z_o
);

  instr_type_e     itype;
  logic [3:0]      op;
  word_t           offset;
  word_t           op1;
  word_t           op2;
  alu_func_e       func;
  logic            ext_sel;
  word_t           alu_out;
  logic [WORD_W:0] wide;
  logic            carry;
  logic            ovf;

  assign itype  = ir_type(ir_i);
  assign op     = ir_op(ir_i);
  assign offset = ir_woffset(ir_i);

  // ********************************************************************
  // Operand and function selection
  // ********************************************************************

  always_comb
  begin
    op1     = reg_data1_i;
    op2     = reg_data2_i;
    func    = ALU_ADD;
    ext_sel = 1'b0;
    case (itype)
      T_ALU:
      begin
        func = alu_func_e'(op[2:0]);
        if (op[3])
          op2 = ir_simm(ir_i);  // Register-immediate form.
      end
      T_CMP:
        func = ALU_SUB;
      T_LOAD, T_STORE, T_JUMP:
      begin
        op2     = offset;
        ext_sel = ir_size(ir_i);  // Extended form carries an absolute address.
      end
      T_BRANCH:
      begin
        op1 = pc_i;
        op2 = offset;
      end
      default:
      begin
      end
    endcase
  end

  // ********************************************************************
  // ALU
  // ********************************************************************

  always_comb
  begin
    wide    = '0;
    carry   = 1'b0;
    ovf     = 1'b0;
    alu_out = '0;
    case (func)
      ALU_ADD:
      begin
        wide    = {1'b0, op1} + {1'b0, op2};
        alu_out = wide[WORD_W-1:0];
        carry   = wide[WORD_W];
        ovf     = (op1[WORD_W-1] == op2[WORD_W-1]) && (alu_out[WORD_W-1] != op1[WORD_W-1]);
      end
      ALU_SUB:
      begin
        wide    = {1'b0, op1} - {1'b0, op2};
        alu_out = wide[WORD_W-1:0];
        carry   = wide[WORD_W];  // Set on unsigned borrow.
        ovf     = (op1[WORD_W-1] != op2[WORD_W-1]) && (alu_out[WORD_W-1] != op1[WORD_W-1]);
      end
      ALU_AND: alu_out = op1 & op2;
      ALU_OR:  alu_out = op1 | op2;
      ALU_XOR: alu_out = op1 ^ op2;
      ALU_SHL: alu_out = op1 << op2[4:0];
      ALU_SHR: alu_out = op1 >> op2[4:0];
      ALU_ASR: alu_out = word_t'($signed(op1) >>> op2[4:0]);
      default: alu_out = '0;
    endcase
  end

  assign alu_result_o = ext_sel ? ir_ext(ir_i) : alu_out;
  assign alu_c_o      = carry;
  assign alu_v_o      = ovf;
  assign alu_n_o      = alu_out[WORD_W-1];
  assign alu_z_o      = (alu_out == '0);

  // A difference of zero means the subtracted operands were equal.
  always_comb
  begin
    if (func == ALU_SUB)
      zero_flag_chk: assert (alu_z_o == (op1 == op2))
        else $error("Zero flag disagrees with the subtracted operands.");
  end

endmodule

//--- src/exec_pkg.sv
package exec_pkg;

  // ********************************************************************
  // Word and instruction types
  // ********************************************************************

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [2*WORD_W-1:0] instr_t;  // Base word in the low half, extension in the high.
  typedef logic [2:0]          ccr_t;    // Bit 2 is carry, bit 1 less-than, bit 0 zero.
  typedef logic [1:0]          reg_write_t;

  localparam reg_write_t WRITE_NONE = 2'b00;
  localparam reg_write_t WRITE_FULL = 2'b11;

  // ********************************************************************
  // Instruction fields
  // ********************************************************************

  localparam int TYPE_MSB = 31;
  localparam int TYPE_LSB = 28;
  localparam int OP_MSB   = 27;
  localparam int OP_LSB   = 24;
  localparam int IMM_MSB  = 15;
  localparam int IMM_LSB  = 1;
  localparam int IMM_W    = IMM_MSB - IMM_LSB + 1;
  localparam int SIZE_BIT = 0;
  localparam int EXT_LSB  = 32;

  // Codes 8 to 15 are treated as no-ops.
  typedef enum logic [3:0] {
    T_ALU    = 4'd0,
    T_CMP    = 4'd1,
    T_MOV    = 4'd2,
    T_LDI    = 4'd3,
    T_LOAD   = 4'd4,
    T_STORE  = 4'd5,
    T_BRANCH = 4'd6,
    T_JUMP   = 4'd7
  } instr_type_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5,
    ALU_SHR = 3'd6,  // Logical.
    ALU_ASR = 3'd7
  } alu_func_e;

  // ********************************************************************
  // Field extraction
  // ********************************************************************

  function automatic instr_type_e ir_type(input instr_t ir);
    return instr_type_e'(ir[TYPE_MSB:TYPE_LSB]);
  endfunction

  function automatic logic [3:0] ir_op(input instr_t ir);
    return ir[OP_MSB:OP_LSB];
  endfunction

  function automatic logic ir_size(input instr_t ir);
    return ir[SIZE_BIT];
  endfunction

  function automatic word_t ir_simm(input instr_t ir);
    return {{(WORD_W-IMM_W){ir[IMM_MSB]}}, ir[IMM_MSB:IMM_LSB]};
  endfunction

  function automatic word_t ir_uimm(input instr_t ir);
    return {{(WORD_W-IMM_W){1'b0}}, ir[IMM_MSB:IMM_LSB]};
  endfunction

  // Branch and address offsets count words, not bytes.
  function automatic word_t ir_woffset(input instr_t ir);
    return ir_simm(ir) << 2;
  endfunction

  function automatic word_t ir_ext(input instr_t ir);
    return ir[EXT_LSB +: WORD_W];
  endfunction

endpackage
